// ==== uart_mux.f ====
+incdir+source
+incdir+tb
source/uart_mux_pkg.sv
source/uart_fifo.sv
source/uart_chan_dispatch.sv
source/uart_tx_engine.sv
source/uart_mux_top.sv
tb/uart_mux_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= uart_mux_tb
SEED      ?= 0
FILELIST  ?= uart_mux.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard source/*.svh tb/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and check the result"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP SEED FILELIST BUILD_DIR VFLAGS"

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/uart_mux_tb_tasks.svh ====
`ifndef UART_MUX_TB_TASKS_SVH
`define UART_MUX_TB_TASKS_SVH

// --------------------
// Checks and bookkeeping
// --------------------

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	checks_run++;
	if (expected !== actual)
	begin
		errors++;
		$display("** Error %s: expected %0h, actual %0h", name, expected, actual);
	end
endtask

task automatic start_test(input string name);
	cur_test    = name;
	test_errors = errors;
	tests_run++;
endtask

task automatic finish_test();
	if (errors == test_errors)
		$display("Test %s: passed", cur_test);
	else
		$display("Test %s: failed with %0d errors", cur_test, errors - test_errors);
endtask

task automatic fail_on_timeout(input string what);
	errors++;
	$display("Timeout in test %s while waiting for %s", cur_test, what);
	end_run();
endtask

// --------------------
// Waits
// --------------------

// Waits for a level of in_ready_o or busy_o on falling clock edges
task automatic wait_level(input bit on_ready, input logic level);
	int n;
	n = 0;
	@(negedge clk_i);
	while ((on_ready ? in_ready_o : busy_o) !== level)
	begin
		if (n == WAIT_LIMIT)
			fail_on_timeout(on_ready ? "in_ready_o" : "busy_o");
		@(negedge clk_i);
		n++;
	end
endtask

task automatic wait_pairs(input int count);
	int n;
	n = 0;
	@(negedge clk_i);
	while (pairs_checked < count)
	begin
		if (n == WAIT_LIMIT)
			fail_on_timeout("decoded character pairs");
		@(negedge clk_i);
		n++;
	end
endtask

// --------------------
// Stimulus
// --------------------

// Offers one tagged byte and holds it until the DUT takes it
task automatic send_byte(input int chan, input byte_t data);
	int n;
	@(posedge clk_i);
	#1;
	in_valid_i = 1'b1;
	in_chan_i  = chan_t'(chan);
	in_data_i  = data;
	n = 0;
	@(negedge clk_i);
	while (!in_ready_o)
	begin
		if (n == WAIT_LIMIT)
			fail_on_timeout("in_ready_o during a send");
		@(negedge clk_i);
		n++;
	end
	// Transfer on this edge
	@(posedge clk_i);
	#1;
	in_valid_i = 1'b0;
	model_q[chan].push_back(data);
endtask

task automatic pulse_clear();
	@(posedge clk_i);
	#1;
	clr_i = 1'b1;
	@(posedge clk_i);
	#1;
	clr_i = 1'b0;
	// Queued bytes are gone but the one on the line stays
	for (int c = 0; c < CH; c++)
		model_q[c].delete();
endtask

`endif

// ==== tb/uart_mux_tb.sv ====
`timescale 1ns/1ns

`include "uart_mux_settings.svh"

module uart_mux_tb
	import uart_mux_pkg::*;
	();

	localparam int CH         = `UART_MUX_CHANNELS;
	localparam int CPB        = `UART_MUX_CLKS_PER_BIT;
	localparam int LEVEL_W    = $bits(level_t);
	localparam int WAIT_LIMIT = 40 * 20 * CPB;

	logic                  clk_i = 1'b0;
	logic                  rst_ni;
	logic                  clr_i;
	logic                  in_valid_i;
	chan_t                 in_chan_i;
	byte_t                 in_data_i;
	logic                  in_ready_o;
	logic [CH*LEVEL_W-1:0] levels_o;
	logic                  tx_o;
	logic                  busy_o;

	integer seed = 32'h67f4fa31;
	int     errors;
	int     checks_run;
	int     tests_run;
	int     test_errors;
	string  cur_test;
	int     starts_seen;
	int     pairs_checked;

	// Per-channel model of bytes accepted but not yet on the line
	byte_t model_q [CH][$];
	chan_t last_served;

	// Predicted pair {found, header, data} and the 20 sampled line bits
	logic [16:0] pred_q [$];
	logic [19:0] bits_q [$];

	always #4 clk_i = ~clk_i;

	uart_mux_top dut_i (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.clr_i      (clr_i),
		.in_valid_i (in_valid_i),
		.in_chan_i  (in_chan_i),
		.in_data_i  (in_data_i),
		.in_ready_o (in_ready_o),
		.levels_o   (levels_o),
		.tx_o       (tx_o),
		.busy_o     (busy_o)
	);

	// Next pair comes from the first pending channel after the one served last
	function automatic logic [16:0] predict_pair();
		int          from;
		chan_t       c;
		logic [16:0] pair;
		from = int'(last_served);
		pair = '0;
		for (int i = 1; i <= CH; i++)
		begin
			c = chan_t'((from + i) % CH);
			if (!pair[16] && model_q[c].size() > 0)
			begin
				pair = {1'b1, byte_t'(`UART_MUX_HDR_BASE + c), model_q[c].pop_front()};
				last_served = c;
			end
		end
		return pair;
	endfunction

	task automatic end_run();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks_run, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	`include "uart_mux_tb_tasks.svh"

	// --------------------
	// Line decoder
	// --------------------
	initial
	begin : line_decoder
		logic [19:0] bits;
		logic [16:0] pred;
		forever
		begin
			@(negedge clk_i);
			if (rst_ni === 1'b1 && tx_o === 1'b0)
			begin
				// Falling start bit follows the pop by one edge
				pred = predict_pair();
				starts_seen++;
				repeat (CPB / 2) @(negedge clk_i);
				bits[0] = tx_o;
				for (int k = 1; k < 20; k++)
				begin
					repeat (CPB) @(negedge clk_i);
					bits[k] = tx_o;
				end
				pred_q.push_back(pred);
				bits_q.push_back(bits);
			end
		end
	end

	// --------------------
	// Compare
	// --------------------
	always @(posedge clk_i)
	begin : compare_pairs
		logic [16:0] pred;
		logic [19:0] bits;
		if (pred_q.size() > 0)
		begin
			pred = pred_q.pop_front();
			bits = bits_q.pop_front();
			if (!pred[16])
			begin
				errors++;
				$display("Frame on the line in test %s with no byte pending", cur_test);
			end
			check_value({cur_test, " header"}, 32'(pred[15:8]), 32'(bits[8:1]));
			check_value({cur_test, " data"}, 32'(pred[7:0]), 32'(bits[18:11]));
			// Stop, start, stop, start of the two characters
			check_value({cur_test, " framing"}, 32'h0a,
				32'({bits[19], bits[10], bits[9], bits[0]}));
			pairs_checked++;
		end
	end

	initial
	begin : test_sequence
		int                    base;
		int                    popped;
		int                    quiet_starts;
		logic [CH*LEVEL_W-1:0] exp_levels;

		rst_ni      = 1'b0;
		clr_i       = 1'b0;
		in_valid_i  = 1'b0;
		in_chan_i   = '0;
		in_data_i   = '0;
		last_served = chan_t'(CH - 1);
		repeat (3) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;

		start_test("reset_state");
		@(negedge clk_i);
		check_value("reset_state tx_o", 1, 32'(tx_o));
		check_value("reset_state busy_o", 0, 32'(busy_o));
		check_value("reset_state in_ready_o", 1, 32'(in_ready_o));
		check_value("reset_state levels_o", 0, 32'(levels_o));
		finish_test();

		start_test("single_byte");
		base = pairs_checked;
		send_byte(2, byte_t'($random(seed)));
		wait_pairs(base + 1);
		wait_level(1'b0, 1'b0);
		finish_test();

		start_test("channel_order");
		base = pairs_checked;
		for (int i = 0; i < 8; i++)
			send_byte(3, byte_t'($random(seed)));
		wait_pairs(base + 8);
		wait_level(1'b0, 1'b0);
		finish_test();

		start_test("round_robin");
		base = pairs_checked;
		send_byte(1, byte_t'($random(seed)));
		wait_level(1'b0, 1'b1);
		// All channels fill while the first item is on the line
		for (int r = 0; r < 3; r++)
			for (int c = 0; c < CH; c++)
				send_byte(c, byte_t'($random(seed)));
		wait_pairs(base + 1 + 3 * CH);
		wait_level(1'b0, 1'b0);
		finish_test();

		start_test("back_pressure");
		base = pairs_checked;
		for (int i = 0; i < 18; i++)
			send_byte(0, byte_t'($random(seed)));
		wait_level(1'b1, 1'b0);
		wait_level(1'b1, 1'b1);
		wait_pairs(base + 18);
		wait_level(1'b0, 1'b0);
		finish_test();

		start_test("levels_clear");
		base = starts_seen;
		for (int i = 0; i < 5; i++)
			send_byte(1, byte_t'($random(seed)));
		// Last byte lands in its FIFO one edge after the transfer
		repeat (2) @(negedge clk_i);
		#1;
		popped = starts_seen - base;
		exp_levels = '0;
		exp_levels[LEVEL_W +: LEVEL_W] = level_t'(5 - popped);
		check_value("levels_clear levels", 32'(exp_levels), 32'(levels_o));
		pulse_clear();
		@(negedge clk_i);
		#1;
		check_value("levels_clear levels after clear", 0, 32'(levels_o));
		wait_level(1'b0, 1'b0);
		#1;
		quiet_starts = starts_seen;
		repeat (200) @(negedge clk_i);
		#1;
		check_value("levels_clear frame starts after clear", quiet_starts, starts_seen);
		finish_test();

		end_run();
	end

endmodule

// ==== source/uart_mux_top.sv ====
`timescale 1ns/1ns

`include "uart_mux_settings.svh"

module uart_mux_top
	import uart_mux_pkg::*;
	(
	input  logic  clk_i,
	input  logic  rst_ni,
	input  logic  clr_i,

	// Host side
	input  logic  in_valid_i,
	input  chan_t in_chan_i,
	input  byte_t in_data_i,
	output logic  in_ready_o,

	// Fill level of every channel FIFO, channel 0 in the low bits
	output logic [`UART_MUX_CHANNELS*$bits(level_t)-1:0] levels_o,

	// Serial line
	output logic  tx_o,
	output logic  busy_o
	);

	localparam int unsigned LEVEL_W = $bits(level_t);

	logic [`UART_MUX_CHANNELS-1:0] fifo_valid;
	logic [`UART_MUX_CHANNELS-1:0] fifo_ready;
	byte_t                         fifo_data;

	logic [`UART_MUX_CHANNELS-1:0] pop_valid;
	logic [`UART_MUX_CHANNELS-1:0] pop_ready;
	byte_t                         pop_data [`UART_MUX_CHANNELS];

	uart_chan_dispatch #(
		.NUM_CHANNELS (`UART_MUX_CHANNELS)
	) dispatch_i (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.clr_i        (clr_i),
		.in_valid_i   (in_valid_i),
		.in_chan_i    (in_chan_i),
		.in_data_i    (in_data_i),
		.in_ready_o   (in_ready_o),
		.fifo_valid_o (fifo_valid),
		.fifo_data_o  (fifo_data),
		.fifo_ready_i (fifo_ready)
	);

	// One queue per channel
	for (genvar k = 0; k < `UART_MUX_CHANNELS; k++)
	begin : gen_fifo
		uart_fifo #(
			.BUFFER_DEPTH (`UART_MUX_FIFO_DEPTH)
		) fifo_i (
			.clk_i      (clk_i),
			.rst_ni     (rst_ni),
			.clr_i      (clr_i),
			.valid_i    (fifo_valid[k]),
			.data_i     (fifo_data),
			.ready_o    (fifo_ready[k]),
			.valid_o    (pop_valid[k]),
			.data_o     (pop_data[k]),
			.ready_i    (pop_ready[k]),
			.elements_o (levels_o[k*LEVEL_W +: LEVEL_W])
		);
	end

	uart_tx_engine #(
		.NUM_CHANNELS (`UART_MUX_CHANNELS),
		.CLKS_PER_BIT (`UART_MUX_CLKS_PER_BIT),
		.HDR_BASE     (`UART_MUX_HDR_BASE)
	) engine_i (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.pop_valid_i (pop_valid),
		.pop_data_i  (pop_data),
		.pop_ready_o (pop_ready),
		.tx_o        (tx_o),
		.busy_o      (busy_o)
	);

endmodule

// ==== source/uart_tx_engine.sv ====
`timescale 1ns/1ns

module uart_tx_engine
	import uart_mux_pkg::*;
	#(
	parameter int unsigned NUM_CHANNELS = 4,
	parameter int unsigned CLKS_PER_BIT = 4,
	parameter byte_t       HDR_BASE     = 8'hA0
	)
	(
	input  logic                    clk_i,
	input  logic                    rst_ni,

	input  logic [NUM_CHANNELS-1:0] pop_valid_i,
	input  byte_t                   pop_data_i [NUM_CHANNELS],
	output logic [NUM_CHANNELS-1:0] pop_ready_o,

	output logic                    tx_o,
	output logic                    busy_o
	);

	localparam int unsigned BAUD_W = $clog2(CLKS_PER_BIT + 1);

	tx_state_t         state_q;
	chan_t             last_q;
	logic [BAUD_W-1:0] baud_q;
	logic [3:0]        bit_q;
	logic              tx_q;
	logic [8:0]        shift_q;
	byte_t             data_q;

	chan_t sel_chan;
	logic  sel_found;
	logic  start;
	logic  bit_end;
	logic  char_end;

	// --------------------
	// Round-robin search
	// --------------------
	always_comb
	begin : rr_search
		chan_t cand;
		sel_found = 1'b0;
		sel_chan  = last_q;
		// Start one past the channel served last
		for (int i = 1; i <= NUM_CHANNELS; i++)
		begin
			cand = chan_t'((int'(last_q) + i) % NUM_CHANNELS);
			if (!sel_found && pop_valid_i[cand])
			begin
				sel_found = 1'b1;
				sel_chan  = cand;
			end
		end
	end

	assign start    = (state_q == IDLE) && sel_found;
	assign bit_end  = (baud_q == BAUD_W'(CLKS_PER_BIT - 1));
	assign char_end = bit_end && (bit_q == 4'd9);

	always_comb
	begin
		pop_ready_o = '0;
		if (start)
			pop_ready_o[sel_chan] = 1'b1;
	end

	// --------------------
	// Phase and bit timing
	// --------------------
	always_ff @(posedge clk_i or negedge rst_ni)
	begin
		if (!rst_ni)
		begin
			state_q <= IDLE;
			last_q  <= chan_t'(NUM_CHANNELS - 1);
			baud_q  <= '0;
			bit_q   <= '0;
			tx_q    <= 1'b1;
		end
		else
		begin
			case (state_q)
				IDLE:
				begin
					if (start)
					begin
						state_q <= HDR;
						last_q  <= sel_chan;
						baud_q  <= '0;
						bit_q   <= '0;
						// Start bit of the header
						tx_q    <= 1'b0;
					end
				end
				HDR, DATA:
				begin
					if (!bit_end)
						baud_q <= baud_q + 1'b1;
					else
					begin
						baud_q <= '0;
						if (char_end)
						begin
							// Line stays at the stop level when going idle
							if (state_q == HDR)
							begin
								state_q <= DATA;
								bit_q   <= '0;
								tx_q    <= 1'b0;
							end
							else
								state_q <= IDLE;
						end
						else
						begin
							bit_q <= bit_q + 1'b1;
							tx_q  <= shift_q[0];
						end
					end
				end
				default:
					state_q <= IDLE;
			endcase
		end
	end

	// Remaining data bits plus stop bit, LSB first
	always_ff @(posedge clk_i)
	begin
		if (start)
		begin
			shift_q <= {1'b1, byte_t'(HDR_BASE + byte_t'(sel_chan))};
			data_q  <= pop_data_i[sel_chan];
		end
		else if ((state_q != IDLE) && bit_end)
		begin
			if (char_end && (state_q == HDR))
				shift_q <= {1'b1, data_q};
			else
				shift_q <= {1'b1, shift_q[8:1]};
		end
	end

	assign tx_o   = tx_q;
	assign busy_o = (state_q != IDLE);

endmodule

// ==== source/uart_chan_dispatch.sv ====
`timescale 1ns/1ns

module uart_chan_dispatch
	import uart_mux_pkg::*;
	#(
	parameter int unsigned NUM_CHANNELS = 4
	)
	(
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    clr_i,

	// Tagged byte from the host
	input  logic                    in_valid_i,
	input  chan_t                   in_chan_i,
	input  byte_t                   in_data_i,
	output logic                    in_ready_o,

	// Toward the FIFO bank
	output logic [NUM_CHANNELS-1:0] fifo_valid_o,
	output byte_t                   fifo_data_o,
	input  logic [NUM_CHANNELS-1:0] fifo_ready_i
	);

	logic  hold_valid_q;
	chan_t hold_chan_q;
	byte_t hold_data_q;

	logic accept;
	logic write;

	// Target FIFO takes the held byte
	assign write  = hold_valid_q && fifo_ready_i[hold_chan_q];
	// Slot is free now or frees up this cycle, closed while clearing
	assign in_ready_o = !clr_i && (!hold_valid_q || write);
	assign accept = in_valid_i && in_ready_o;

	always_comb
	begin
		fifo_valid_o = '0;
		if (hold_valid_q)
			fifo_valid_o[hold_chan_q] = 1'b1;
	end

	assign fifo_data_o = hold_data_q;

	always_ff @(posedge clk_i or negedge rst_ni)
	begin
		if (!rst_ni)
			hold_valid_q <= 1'b0;
		else if (clr_i)
			hold_valid_q <= 1'b0;
		else if (accept)
			hold_valid_q <= 1'b1;
		else if (write)
			hold_valid_q <= 1'b0;
	end

	// Tag and byte of the held entry
	always_ff @(posedge clk_i)
	begin
		if (accept)
		begin
			hold_chan_q <= in_chan_i;
			hold_data_q <= in_data_i;
		end
	end

endmodule

// ==== source/uart_fifo.sv ====
`timescale 1ns/1ns

module uart_fifo
	import uart_mux_pkg::*;
	#(
	parameter int unsigned BUFFER_DEPTH = 16
	)
	(
	input  logic   clk_i,
	input  logic   rst_ni,
	input  logic   clr_i,

	// Write side
	input  logic   valid_i,
	input  byte_t  data_i,
	output logic   ready_o,

	// Read side
	output logic   valid_o,
	output byte_t  data_o,
	input  logic   ready_i,

	output level_t elements_o
	);

	localparam int unsigned PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	level_t           count_q;
	byte_t            mem [BUFFER_DEPTH];

	logic full;
	logic push;
	logic pop;

	assign full = (count_q == level_t'(BUFFER_DEPTH));
	assign push = valid_i && !full;
	assign pop  = ready_i && valid_o;

	// --------------------
	// Element counter
	// --------------------
	always_ff @(posedge clk_i or negedge rst_ni)
	begin
		if (!rst_ni)
			count_q <= '0;
		else if (clr_i)
			count_q <= '0;
		else if (push && !pop)
			count_q <= count_q + 1'b1;
		else if (pop && !push)
			count_q <= count_q - 1'b1;
		// Push and pop together leave the count alone
	end

	// --------------------
	// Pointers
	// --------------------
	always_ff @(posedge clk_i or negedge rst_ni)
	begin
		if (!rst_ni)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end
		else if (clr_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end
		else
		begin
			if (push)
			begin
				if (wr_ptr_q == PTR_W'(BUFFER_DEPTH - 1))
					wr_ptr_q <= '0;
				else
					wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop)
			begin
				if (rd_ptr_q == PTR_W'(BUFFER_DEPTH - 1))
					rd_ptr_q <= '0;
				else
					rd_ptr_q <= rd_ptr_q + 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge clk_i)
	begin
		if (push)
			mem[wr_ptr_q] <= data_i;
	end

	// Head of queue is read without a register stage
	assign data_o     = mem[rd_ptr_q];
	assign valid_o    = (count_q != '0);
	assign ready_o    = !full;
	assign elements_o = count_q;

endmodule

// ==== source/uart_mux_pkg.sv ====
`include "uart_mux_settings.svh"

package uart_mux_pkg;

	// One UART payload byte
	typedef logic [7:0] byte_t;

	// Channel index
	typedef logic [$clog2(`UART_MUX_CHANNELS)-1:0] chan_t;

	// FIFO fill level, one extra bit so a full FIFO is representable
	typedef logic [$clog2(`UART_MUX_FIFO_DEPTH):0] level_t;

	// Transmit engine phases
	typedef enum logic [1:0]
	{
		IDLE,
		HDR,
		DATA
	} tx_state_t;

endpackage

// ==== source/uart_mux_settings.svh ====
`ifndef UART_MUX_SETTINGS_SVH
`define UART_MUX_SETTINGS_SVH

// Number of byte channels merged onto the line
`define UART_MUX_CHANNELS 4
// Entries per channel FIFO
`define UART_MUX_FIFO_DEPTH 16
// Clock cycles per serial bit
`define UART_MUX_CLKS_PER_BIT 4
// Header character for channel c is this base plus c
`define UART_MUX_HDR_BASE 8'hA0

`endif
